// File: rf_pkg.sv
// Widths and offsets fixed for the 32x6 power-gated register file; APB offsets are byte addresses
package rf_pkg;

    // ------------------------------
    // Array geometry
    // ------------------------------

    // Logical words are 6 bits and sit in an 8-bit physical array
    localparam int rf_addr_w = 5;
    localparam int rf_data_w = 6;
    localparam int rf_phys_w = 8;
    localparam int rf_depth  = 32;

    typedef logic [rf_addr_w-1:0] rf_addr_t;
    typedef logic [rf_data_w-1:0] rf_data_t;
    typedef logic [rf_phys_w-1:0] rf_phys_t;

    // ------------------------------
    // Power controller
    // ------------------------------

    // Sequencer states, isolation always brackets the switch being off
    typedef enum logic [2:0] {
        pg_off        = 3'd0,
        pg_power_up   = 3'd1,
        pg_on         = 3'd2,
        pg_isolate    = 3'd3,
        pg_power_down = 3'd4
    } pg_state_e;

    // CTRL bit 0 is power_off_req and comes out of reset set
    localparam logic [7:0] apb_ctrl_offset = 8'h00;

    // STATUS is read-only: bit 0 powered, bit 1 busy, bit 2 isolated
    localparam logic [7:0] apb_status_offset = 8'h04;

endpackage

// File: rf_port_if.sv
// Plain bundle with no clocks inside; the write and read halves belong to different clock domains
interface rf_port_if;

    import rf_pkg::*;

    // Write half, lives in the wclk domain
    logic     we;
    rf_addr_t waddr;
    rf_phys_t wdata;

    // Read half, lives in the rclk domain
    logic     re;
    rf_addr_t raddr;
    rf_phys_t rdata;

    // The wrapper drives the request side of each half
    modport wr_master (
        output we,
        output waddr,
        output wdata
    );

    modport rd_master (
        output re,
        output raddr,
        input  rdata
    );

    // The array receives requests and returns read data
    modport wr_slave (
        input  we,
        input  waddr,
        input  wdata
    );

    modport rd_slave (
        input  re,
        input  raddr,
        output rdata
    );

endinterface

// File: rf_reset_sync.sv
// Needs sync_stages of at least 1; release takes sync_stages clk edges after arst_n rises
module rf_reset_sync #(
    parameter int sync_stages = 2
) (
     input  logic clk
    ,input  logic arst_n
    ,output logic rst_n_sync
);

    // Shift register of ones, the oldest stage is the synchronized reset
    logic [sync_stages-1:0] sync_q;

    // Assertion is immediate on arst_n, release walks a one through the chain
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= (sync_q << 1) | sync_stages'(1);
        end
    end

    assign rst_n_sync = sync_q[sync_stages-1];

    // ------------------------------
    // Checks
    // ------------------------------

    // Release comes only once arst_n has been high across the whole chain
    a_rst_held: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(rst_n_sync) |-> $past(arst_n, sync_stages)
    ) else $error("rst_n_sync released too early");

endmodule

// File: rf_array_2p.sv
// Behavioral model; contents survive power-off and writes are dropped while the switch is off
module rf_array_2p #(
    parameter int pg_delay = 4
) (
     input  logic               wclk
    ,input  logic               rclk
    ,input  logic               rst_n
    ,rf_port_if.wr_slave        wr
    ,rf_port_if.rd_slave        rd
    ,input  logic               isol_en
    ,input  logic               pwr_enable_b_in
    ,output logic               pwr_enable_b_out
);

    import rf_pkg::*;

    rf_phys_t              mem [rf_depth];
    rf_phys_t              rdata_q;
    logic [pg_delay-1:0]   pwr_chain_q;

    // ------------------------------
    // Power switch
    // ------------------------------

    // The enable ripples through the switch segments one wclk at a time
    // and the last segment is reported back to the controller
    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_chain_q <= '1;
        end else begin
            pwr_chain_q <= {pwr_chain_q[pg_delay-2:0], pwr_enable_b_in};
        end
    end

    assign pwr_enable_b_out = pwr_chain_q[pg_delay-1];

    // ------------------------------
    // Storage
    // ------------------------------

    // Write port, only the fully powered array accepts data
    always_ff @(posedge wclk) begin
        if (wr.we && !pwr_enable_b_out) begin
            mem[wr.waddr] <= wr.wdata;
        end
    end

    // Read port registers the entry, so a same-address write in the same cycle returns old data
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (rd.re) begin
            rdata_q <= mem[rd.raddr];
        end
    end

    // Clamp is combinational so isolation takes hold without waiting for a read
    assign rd.rdata = isol_en ? '0 : rdata_q;

    // ------------------------------
    // Checks
    // ------------------------------

    a_waddr_range: assert property (
        @(posedge wclk) disable iff (!rst_n) wr.we |-> (int'(wr.waddr) < rf_depth)
    ) else $error("write address out of range");

    a_raddr_range: assert property (
        @(posedge rclk) disable iff (!rst_n) rd.re |-> (int'(rd.raddr) < rf_depth)
    ) else $error("read address out of range");

    // The controller must have isolated the array before its switch reports off
    a_read_isolated: assert property (
        @(posedge rclk) disable iff (!rst_n) (rd.re && pwr_enable_b_out) |-> isol_en
    ) else $error("read from an unpowered array without isolation");

endmodule

// File: rf_pg_32x6.sv
// Pad bits of the 8-bit array are written as zero and never returned; rdata is zero while isolated
module rf_pg_32x6 #(
    parameter int pg_delay    = 4,
    parameter int sync_stages = 2
) (
     input  logic              wclk
    ,input  logic              rclk
    ,input  logic              arst_n
    ,input  logic              we
    ,input  rf_pkg::rf_addr_t  waddr
    ,input  rf_pkg::rf_data_t  wdata
    ,input  logic              re
    ,input  rf_pkg::rf_addr_t  raddr
    ,output rf_pkg::rf_data_t  rdata
    ,input  logic              isol_en
    ,input  logic              pwr_enable_b_in
    ,output logic              pwr_enable_b_out
);

    import rf_pkg::*;

    logic array_rst_n;

    // Array reset is released on rclk since the read output flop lives there
    rf_reset_sync #(
        .sync_stages (sync_stages)
    ) i_array_rst_sync (
         .clk        (rclk)
        ,.arst_n     (arst_n)
        ,.rst_n_sync (array_rst_n)
    );

    rf_port_if i_port ();

    // ------------------------------
    // Logical to physical mapping
    // ------------------------------

    assign i_port.we    = we;
    assign i_port.waddr = waddr;
    // Upper pad bits are tied low
    assign i_port.wdata = {{(rf_phys_w - rf_data_w){1'b0}}, wdata};

    assign i_port.re    = re;
    assign i_port.raddr = raddr;
    assign rdata        = i_port.rdata[rf_data_w-1:0];

    rf_array_2p #(
        .pg_delay (pg_delay)
    ) i_rf (
         .wclk             (wclk)
        ,.rclk             (rclk)
        ,.rst_n            (array_rst_n)
        ,.wr               (i_port.wr_slave)
        ,.rd               (i_port.rd_slave)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

endmodule

// File: rf_pg_ctrl.sv
// APB slave with no wait states; only pwdata bit 0 is stored and paddr is fully decoded
module rf_pg_ctrl (
     input  logic        wclk
    ,input  logic        arst_n
    ,input  logic        psel
    ,input  logic        penable
    ,input  logic        pwrite
    ,input  logic [7:0]  paddr
    ,input  logic [31:0] pwdata
    ,output logic [31:0] prdata
    ,output logic        pready
    ,output logic        pslverr
    ,output logic        isol_en
    ,output logic        pwr_enable_b_in
    ,input  logic        pwr_enable_b_out
);

    import rf_pkg::*;

    logic       access;
    logic       ctrl_hit;
    logic       status_hit;
    logic       power_off_req_q;
    logic       busy;
    logic [2:0] status;
    pg_state_e  state_q;
    pg_state_e  state_d;

    // ------------------------------
    // APB decode
    // ------------------------------

    // Every transfer finishes in its ACCESS cycle
    assign pready     = 1'b1;
    assign access     = psel && penable;
    assign ctrl_hit   = (paddr == apb_ctrl_offset);
    assign status_hit = (paddr == apb_status_offset);

    // STATUS is read-only and anything off the map errors
    assign pslverr = access && ((pwrite && status_hit) || !(ctrl_hit || status_hit));

    // CTRL write lands at the end of ACCESS, so the FSM sees it one cycle on
    always_ff @(posedge wclk or negedge arst_n) begin
        if (!arst_n) begin
            power_off_req_q <= 1'b1;
        end else if (access && pwrite && ctrl_hit) begin
            power_off_req_q <= pwdata[0];
        end
    end

    // Busy covers a request that is pending but not yet reached
    assign busy   = !((state_q == pg_on && !power_off_req_q) ||
                      (state_q == pg_off && power_off_req_q));
    assign status = {isol_en, busy, state_q == pg_on};

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (ctrl_hit) begin
                prdata = {31'd0, power_off_req_q};
            end else if (status_hit) begin
                prdata = {29'd0, status};
            end
        end
    end

    // ------------------------------
    // Power sequencer
    // ------------------------------

    always_ff @(posedge wclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= pg_off;
        end else begin
            state_q <= state_d;
        end
    end

    // Isolate before the switch opens, and close the switch before dropping isolation
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            pg_off:        if (!power_off_req_q) state_d = pg_power_up;
            pg_power_up:   if (!pwr_enable_b_out) state_d = pg_on;
            pg_on:         if (power_off_req_q) state_d = pg_isolate;
            pg_isolate:    state_d = pg_power_down;
            pg_power_down: if (pwr_enable_b_out) state_d = pg_off;
            default:       state_d = pg_off;
        endcase
    end

    // Only pg_on runs unisolated; the switch is open in pg_off and pg_power_down
    assign isol_en         = (state_q != pg_on);
    assign pwr_enable_b_in = (state_q == pg_off) || (state_q == pg_power_down);

    // ------------------------------
    // Checks
    // ------------------------------

    // The switch may only open once isolation has already held for a cycle
    a_isol_before_off: assert property (
        @(posedge wclk) disable iff (!arst_n) $rose(pwr_enable_b_in) |-> $past(isol_en)
    ) else $error("power switch opened without isolation");

    // Isolation may only lift once the switch reports fully on
    a_power_before_deisol: assert property (
        @(posedge wclk) disable iff (!arst_n) $fell(isol_en) |-> !pwr_enable_b_out
    ) else $error("isolation dropped before power was good");

endmodule

// File: rf_pg_top.sv
// Single arst_n for both domains; the array is usable only after STATUS reports powered
module rf_pg_top #(
    parameter int pg_delay    = 4,
    parameter int sync_stages = 2
) (
     input  logic              wclk
    ,input  logic              rclk
    ,input  logic              arst_n
    // APB slave
    ,input  logic              psel
    ,input  logic              penable
    ,input  logic              pwrite
    ,input  logic [7:0]        paddr
    ,input  logic [31:0]       pwdata
    ,output logic [31:0]       prdata
    ,output logic              pready
    ,output logic              pslverr
    // Memory ports
    ,input  logic              we
    ,input  rf_pkg::rf_addr_t  waddr
    ,input  rf_pkg::rf_data_t  wdata
    ,input  logic              re
    ,input  rf_pkg::rf_addr_t  raddr
    ,output rf_pkg::rf_data_t  rdata
);

    // Power handshake between controller and array
    logic isol_en;
    logic pwr_enable_b_in;
    logic pwr_enable_b_out;

    rf_pg_ctrl i_pg_ctrl (
         .wclk             (wclk)
        ,.arst_n           (arst_n)
        ,.psel             (psel)
        ,.penable          (penable)
        ,.pwrite           (pwrite)
        ,.paddr            (paddr)
        ,.pwdata           (pwdata)
        ,.prdata           (prdata)
        ,.pready           (pready)
        ,.pslverr          (pslverr)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    rf_pg_32x6 #(
        .pg_delay    (pg_delay),
        .sync_stages (sync_stages)
    ) i_rf_pg (
         .wclk             (wclk)
        ,.rclk             (rclk)
        ,.arst_n           (arst_n)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

endmodule

// File: rf_pg_tb.sv
// Drives wclk and rclk from one clock; memory contents are rewritten before being read after power-up
module rf_pg_tb;

    import rf_pkg::*;

    localparam int pg_delay    = 4;
    localparam int sync_stages = 2;
    // A power transition has to finish within this many cycles
    localparam int poll_limit  = 4 * pg_delay + 10;

    typedef enum logic [2:0] {
        op_apb_write, op_apb_read, op_power_up, op_power_down, op_mem_write, op_mem_read
    } op_e;

    // One table row: the operation, its operands and what must come back
    typedef struct {
        op_e         op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] exp_val;
        logic        exp_err;
    } step_t;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        we;
    rf_addr_t    waddr;
    rf_data_t    wdata;
    logic        re;
    rf_addr_t    raddr;
    rf_data_t    rdata;

    step_t       steps [$];
    rf_data_t    shadow [rf_depth];
    int          seed;
    int          cycle_count;
    int          cycle_limit;
    // Value the read port should still hold from the previous read
    rf_data_t    held_rdata;
    logic        held_valid;

    rf_pg_top #(
        .pg_delay    (pg_delay),
        .sync_stages (sync_stages)
    ) i_rf_pg_top (
         .wclk (clk), .rclk (clk), .arst_n (arst_n)
        ,.psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr)
        ,.pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr)
        ,.we (we), .waddr (waddr), .wdata (wdata)
        ,.re (re), .raddr (raddr), .rdata (rdata)
    );

    // ------------------------------
    // Clock and watchdog
    // ------------------------------

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // The limit is set at time zero, before the first rising edge
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= cycle_limit) begin
                abort_run($sformatf("Run did not finish within %0d cycles", cycle_limit));
            end
        end
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic compare_rdata(input rf_data_t exp, input rf_data_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR at %0t: rdata expected 0x%02h got 0x%02h", $time, exp, act));
        end
    endtask

    task automatic compare_prdata(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR at %0t: prdata expected 0x%08h got 0x%08h",
                                $time, exp, act));
        end
    endtask

    task automatic compare_pslverr(input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR at %0t: pslverr expected %b got %b", $time, exp, act));
        end
    endtask

    task automatic compare_pready(input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR at %0t: pready expected %b got %b", $time, exp, act));
        end
    endtask

    // ------------------------------
    // Bus and memory access
    // ------------------------------

    // SETUP on one falling edge, ACCESS on the next; response is sampled inside ACCESS
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] data, output logic [31:0] rd,
                                output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        // The read mux and pslverr are combinational on the ACCESS inputs
        #1;
        rd  = prdata;
        err = pslverr;
        // No wait states, so every ACCESS cycle completes
        compare_pready(1'b1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic mem_write(input rf_addr_t addr, input rf_data_t data);
        @(negedge clk);
        we    = 1'b1;
        waddr = addr;
        wdata = data;
        @(negedge clk);
        we = 1'b0;
    endtask

    // Read data is registered at the rising edge after re, so it is taken on the next falling edge
    // Just before that rising edge the output still shows the previous read
    task automatic mem_read(input rf_addr_t addr, output rf_data_t early,
                            output rf_data_t data);
        @(negedge clk);
        re    = 1'b1;
        raddr = addr;
        #1;
        early = rdata;
        @(negedge clk);
        data = rdata;
        re   = 1'b0;
    endtask

    // Writes CTRL, then polls STATUS until busy has been seen high and then drops
    task automatic power_change(input logic off, input logic [31:0] exp_status);
        logic [31:0] st;
        logic        err;
        logic        saw_busy;
        int          start;
        apb_transfer(1'b1, apb_ctrl_offset, {31'd0, off}, st, err);
        compare_pslverr(1'b0, err);
        saw_busy = 1'b0;
        start    = cycle_count;
        st       = 32'h2;
        while (st[1]) begin
            if (cycle_count - start > poll_limit) begin
                abort_run($sformatf("Power transition did not finish within %0d cycles",
                                    poll_limit));
            end
            apb_transfer(1'b0, apb_status_offset, '0, st, err);
            compare_pslverr(1'b0, err);
            if (st[1]) begin
                saw_busy = 1'b1;
            end
        end
        if (!saw_busy) begin
            abort_run("STATUS busy never went high during the power transition");
        end
        compare_prdata(exp_status, st);
    endtask

    // ------------------------------
    // Stimulus table
    // ------------------------------

    task automatic add_step(input op_e op, input logic [7:0] addr, input logic [31:0] data,
                            input logic [31:0] exp_val, input logic exp_err);
        step_t s;
        s.op      = op;
        s.addr    = addr;
        s.data    = data;
        s.exp_val = exp_val;
        s.exp_err = exp_err;
        steps.push_back(s);
    endtask

    task automatic build_table();
        rf_data_t d;
        int       a;
        int       fresh [8];
        // Out of reset: isolated and off, CTRL asks for power off, reads clamp to zero
        add_step(op_apb_read, apb_status_offset, '0, 32'h4, 1'b0);
        add_step(op_apb_read, apb_ctrl_offset, '0, 32'h1, 1'b0);
        add_step(op_mem_read, 8'd5, '0, '0, 1'b0);
        add_step(op_power_up, '0, '0, 32'h1, 1'b0);
        // Fill every entry, overwrite a few at random, then read all back
        for (int i = 0; i < rf_depth; i++) begin
            d = rf_data_t'($random(seed));
            shadow[i] = d;
            add_step(op_mem_write, 8'(i), 32'(d), '0, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            a = $random(seed) & (rf_depth - 1);
            d = rf_data_t'($random(seed));
            shadow[a] = d;
            add_step(op_mem_write, 8'(a), 32'(d), '0, 1'b0);
        end
        for (int i = 0; i < rf_depth; i++) begin
            add_step(op_mem_read, 8'(i), '0, 32'(shadow[i]), 1'b0);
        end
        // Powered off, the clamp forces zero whatever the array holds
        add_step(op_power_down, '0, '0, 32'h4, 1'b0);
        for (int i = 0; i < 4; i++) begin
            add_step(op_mem_read, 8'(i * 8), '0, '0, 1'b0);
        end
        add_step(op_power_up, '0, '0, 32'h1, 1'b0);
        for (int i = 0; i < 8; i++) begin
            fresh[i] = $random(seed) & (rf_depth - 1);
            d = rf_data_t'($random(seed));
            shadow[fresh[i]] = d;
            add_step(op_mem_write, 8'(fresh[i]), 32'(d), '0, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            add_step(op_mem_read, 8'(fresh[i]), '0, 32'(shadow[fresh[i]]), 1'b0);
        end
        // Slave errors must leave CTRL and STATUS as they were
        add_step(op_apb_write, apb_status_offset, 32'h1, '0, 1'b1);
        add_step(op_apb_read, 8'h08, '0, '0, 1'b1);
        add_step(op_apb_write, 8'h08, 32'h1, '0, 1'b1);
        add_step(op_apb_read, apb_status_offset, '0, 32'h1, 1'b0);
        add_step(op_apb_read, apb_ctrl_offset, '0, 32'h0, 1'b0);
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] rd32;
        logic        err;
        rf_data_t    rd6;
        rf_data_t    rd_early;
        case (s.op)
            op_apb_write: begin
                apb_transfer(1'b1, s.addr, s.data, rd32, err);
                compare_pslverr(s.exp_err, err);
            end
            op_apb_read: begin
                apb_transfer(1'b0, s.addr, '0, rd32, err);
                compare_pslverr(s.exp_err, err);
                compare_prdata(s.exp_val, rd32);
            end
            // A change of isolation alters what rdata shows, so the held value is lost
            op_power_up: begin
                power_change(1'b0, s.exp_val);
                held_valid = 1'b0;
            end
            op_power_down: begin
                power_change(1'b1, s.exp_val);
                held_valid = 1'b0;
            end
            op_mem_write:  mem_write(rf_addr_t'(s.addr), rf_data_t'(s.data));
            default: begin
                mem_read(rf_addr_t'(s.addr), rd_early, rd6);
                if (held_valid) begin
                    compare_rdata(held_rdata, rd_early);
                end
                compare_rdata(rf_data_t'(s.exp_val), rd6);
                held_rdata = rf_data_t'(s.exp_val);
                held_valid = 1'b1;
            end
        endcase
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        int idx;
        seed       = 87586;
        held_rdata = '0;
        held_valid = 1'b0;
        arst_n     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        we         = 1'b0;
        waddr      = '0;
        wdata      = '0;
        re         = 1'b0;
        raddr      = '0;
        build_table();
        cycle_limit = steps.size() * 20 + 200;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // Let the array reset come out of its synchronizer
        repeat (sync_stages + 2) @(negedge clk);
        for (idx = 0; idx < steps.size(); idx++) begin
            run_step(steps[idx]);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: build.f
rf_pkg.sv
rf_port_if.sv
rf_reset_sync.sv
rf_array_2p.sv
rf_pg_32x6.sv
rf_pg_ctrl.sv
rf_pg_top.sv
rf_pg_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module rf_pg_tb -o sim_rf_pg
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_rf_pg 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
    exit 0
fi
echo "Pass message not found"
exit 1
